/* sim.f */
+incdir+testbench
hw/soc_pkg.sv
hw/ahb_apb_bridge.sv
hw/cmt_timer.sv
hw/intc_ctrl.sv
hw/gpio_port.sv
hw/periph_soc.sv
testbench/tb_periph_soc.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the peripheral SoC testbench with Verilator, then check the log
set -u -o pipefail
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module tb_periph_soc -o tb_periph_soc \
    && ./obj_dir/tb_periph_soc 2>&1 | tee "$LOG" \
    || { echo "Build or simulation run failed"; exit 1; }

grep -q "=== FAIL ===" "$LOG" \
    && { echo "Simulation reported failure"; exit 1; } \
    || { echo "Simulation finished without failure"; exit 0; }

/* testbench/tb_vectors.svh */
// Stimulus and expected-value table, included inside the peripheral SoC testbench module
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_WAIT, OP_PINS} op_e;

// Columns: op, address, write data or pin value or poll mask, expected data, expect ERROR
typedef struct packed {
    op_e         op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp;
    logic        err;
} vec_t;

localparam logic [31:0] A_CMT_CTRL  = soc_pkg::CMT_BASE + 32'(soc_pkg::CMT_CTRL);
localparam logic [31:0] A_CMT_STAT  = soc_pkg::CMT_BASE + 32'(soc_pkg::CMT_STAT);
localparam logic [31:0] A_CMT_CMP0  = soc_pkg::CMT_BASE + 32'(soc_pkg::CMT_CMP0);
localparam logic [31:0] A_CMT_CMP1  = soc_pkg::CMT_BASE + 32'(soc_pkg::CMT_CMP1);
// Hole in the CMT map, reads zero
localparam logic [31:0] A_CMT_HOLE  = soc_pkg::CMT_BASE + 32'h18;
localparam logic [31:0] A_INTC_EN   = soc_pkg::INTC_BASE + 32'(soc_pkg::INTC_ENABLE);
localparam logic [31:0] A_INTC_VEC  = soc_pkg::INTC_BASE + 32'(soc_pkg::INTC_VEC);
localparam logic [31:0] A_GPIO_OUT  = soc_pkg::GPIO_BASE + 32'(soc_pkg::GPIO_OUT);
localparam logic [31:0] A_GPIO_OE   = soc_pkg::GPIO_BASE + 32'(soc_pkg::GPIO_OE);
localparam logic [31:0] A_GPIO_IN   = soc_pkg::GPIO_BASE + 32'(soc_pkg::GPIO_IN);
localparam logic [31:0] A_GPIO_IE   = soc_pkg::GPIO_BASE + 32'(soc_pkg::GPIO_IE);
localparam logic [31:0] A_GPIO_EDGE = soc_pkg::GPIO_BASE + 32'(soc_pkg::GPIO_EDGE);
localparam logic [31:0] A_UNMAPPED  = 32'habcc3000;

localparam int NUM_VEC  = 46;
// Entries filled with the random pin value at run time
localparam int RAND_SET = 8;
localparam int RAND_CHK = 9;

vec_t vec_tab [NUM_VEC] = '{
    // Reset values
    '{OP_READ,  A_GPIO_OUT,  32'h0000_0000, 32'h0000_0000, 1'b0},
    '{OP_READ,  A_GPIO_OE,   32'h0000_0000, 32'h0000_0000, 1'b0},
    '{OP_READ,  A_INTC_VEC,  32'h0000_0000, 32'h0000_0003, 1'b0},
    '{OP_READ,  A_CMT_CTRL,  32'h0000_0000, 32'h0000_0000, 1'b0},
    // GPIO output and direction
    '{OP_WRITE, A_GPIO_OUT,  32'ha5c3_0f96, 32'h0000_0000, 1'b0},
    '{OP_WRITE, A_GPIO_OE,   32'h0000_ffff, 32'h0000_0000, 1'b0},
    '{OP_READ,  A_GPIO_OUT,  32'h0000_0000, 32'ha5c3_0f96, 1'b0},
    '{OP_READ,  A_GPIO_OE,   32'h0000_0000, 32'h0000_ffff, 1'b0},
    // Random input, then clear the edges it left
    '{OP_PINS,  32'h0,       32'h0000_0000, 32'h0000_0000, 1'b0},
    '{OP_READ,  A_GPIO_IN,   32'h0000_0000, 32'h0000_0000, 1'b0},
    '{OP_PINS,  32'h0,       32'h0000_0000, 32'h0000_0000, 1'b0},
    '{OP_WRITE, A_GPIO_EDGE, 32'hffff_ffff, 32'h0000_0000, 1'b0},
    '{OP_READ,  A_GPIO_EDGE, 32'h0000_0000, 32'h0000_0000, 1'b0},
    // GPIO edge interrupt
    '{OP_WRITE, A_INTC_EN,   32'h0000_0004, 32'h0000_0000, 1'b0},
    '{OP_WRITE, A_GPIO_IE,   32'h0000_00f0, 32'h0000_0000, 1'b0},
    '{OP_PINS,  32'h0,       32'h0000_0010, 32'h0000_0000, 1'b0},
    '{OP_READ,  A_GPIO_EDGE, 32'h0000_0000, 32'h0000_0010, 1'b0},
    '{OP_READ,  A_INTC_VEC,  32'h0000_0000, 32'h0000_0002, 1'b0},
    '{OP_WRITE, A_GPIO_EDGE, 32'h0000_0010, 32'h0000_0000, 1'b0},
    '{OP_READ,  A_GPIO_EDGE, 32'h0000_0000, 32'h0000_0000, 1'b0},
    '{OP_READ,  A_INTC_VEC,  32'h0000_0000, 32'h0000_0003, 1'b0},
    // CMT channel 0 match
    '{OP_WRITE, A_INTC_EN,   32'h0000_0007, 32'h0000_0000, 1'b0},
    '{OP_WRITE, A_CMT_CMP0,  32'h0000_0009, 32'h0000_0000, 1'b0},
    '{OP_WRITE, A_CMT_CTRL,  32'h0000_0001, 32'h0000_0000, 1'b0},
    '{OP_WAIT,  A_CMT_STAT,  32'h0000_0001, 32'h0000_0001, 1'b0},
    '{OP_READ,  A_INTC_VEC,  32'h0000_0000, 32'h0000_0000, 1'b0},
    '{OP_WRITE, A_CMT_CTRL,  32'h0000_0000, 32'h0000_0000, 1'b0},
    '{OP_WRITE, A_CMT_STAT,  32'h0000_0001, 32'h0000_0000, 1'b0},
    '{OP_READ,  A_CMT_STAT,  32'h0000_0000, 32'h0000_0000, 1'b0},
    '{OP_READ,  A_INTC_VEC,  32'h0000_0000, 32'h0000_0003, 1'b0},
    // CMT1 against GPIO priority
    '{OP_WRITE, A_CMT_CMP1,  32'h0000_0004, 32'h0000_0000, 1'b0},
    '{OP_WRITE, A_CMT_CTRL,  32'h0000_0002, 32'h0000_0000, 1'b0},
    '{OP_WAIT,  A_CMT_STAT,  32'h0000_0002, 32'h0000_0002, 1'b0},
    '{OP_WRITE, A_CMT_CTRL,  32'h0000_0000, 32'h0000_0000, 1'b0},
    '{OP_PINS,  32'h0,       32'h0000_0030, 32'h0000_0000, 1'b0},
    '{OP_READ,  A_GPIO_EDGE, 32'h0000_0000, 32'h0000_0020, 1'b0},
    '{OP_READ,  A_INTC_VEC,  32'h0000_0000, 32'h0000_0001, 1'b0},
    '{OP_WRITE, A_CMT_STAT,  32'h0000_0002, 32'h0000_0000, 1'b0},
    '{OP_READ,  A_INTC_VEC,  32'h0000_0000, 32'h0000_0002, 1'b0},
    '{OP_WRITE, A_GPIO_EDGE, 32'h0000_0020, 32'h0000_0000, 1'b0},
    '{OP_READ,  A_INTC_VEC,  32'h0000_0000, 32'h0000_0003, 1'b0},
    // Unmapped window, then normal reads again
    '{OP_READ,  A_UNMAPPED,  32'h0000_0000, 32'h0000_0000, 1'b1},
    '{OP_WRITE, A_UNMAPPED,  32'h0000_1234, 32'h0000_0000, 1'b1},
    '{OP_READ,  A_GPIO_OUT,  32'h0000_0000, 32'ha5c3_0f96, 1'b0},
    '{OP_READ,  A_CMT_HOLE,  32'h0000_0000, 32'h0000_0000, 1'b0},
    '{OP_READ,  A_CMT_CMP0,  32'h0000_0000, 32'h0000_0009, 1'b0}
};

`endif

/* testbench/tb_periph_soc.sv */
// Testbench for the peripheral SoC; applies the vector table over the AHB-Lite port and checks
`timescale 1ns/1ps

module tb_periph_soc;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 4;
    localparam int HREADY_LIMIT = 8;
    localparam int POLL_LIMIT   = 32;
    // Worst entry is a full poll run, about 5 cycles per read
    localparam int ENTRY_CYCLES = (POLL_LIMIT + 1) * 6;

    logic                              clk;
    logic                              rst_i;
    logic [soc_pkg::ADDR_W-1:0]        haddr_i;
    soc_pkg::htrans_e                  htrans_i;
    logic                              hwrite_i;
    logic [soc_pkg::DATA_W-1:0]        hwdata_i;
    logic [soc_pkg::DATA_W-1:0]        hrdata_o;
    logic                              hready_o;
    logic                              hresp_o;
    logic [31:0]                       gpio_i;
    logic [31:0]                       gpio_o;
    logic [31:0]                       gpio_oe_o;
    logic                              irq_o;
    logic [1:0]                        irq_vec_o;

    int          errors;
    int          checks;
    int          seed;
    logic [31:0] rand_pins;
    logic [31:0] rdata;

    `include "tb_vectors.svh"

    localparam int WATCHDOG_NS = (NUM_VEC * ENTRY_CYCLES + RESET_CYCLES + 20) * CLK_PERIOD;

    periph_soc #(.GPIO_W(32), .CMT_W(16)) i_periph_soc (
        .clk(clk), .rst_i(rst_i),
        .haddr_i(haddr_i), .htrans_i(htrans_i), .hwrite_i(hwrite_i), .hwdata_i(hwdata_i),
        .hrdata_o(hrdata_o), .hready_o(hready_o), .hresp_o(hresp_o),
        .gpio_i(gpio_i), .gpio_o(gpio_o), .gpio_oe_o(gpio_oe_o),
        .irq_o(irq_o), .irq_vec_o(irq_vec_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] t=%0t ns %s expected %h actual %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic require(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("ERROR at %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    // Port outputs that mirror a register just read
    task automatic ports_match_reg(input logic [31:0] addr, input logic [31:0] exp);
        if (addr == A_GPIO_OUT) begin
            compare_word("gpio_o", exp, gpio_o);
        end else if (addr == A_GPIO_OE) begin
            compare_word("gpio_oe_o", exp, gpio_oe_o);
        end else if (addr == A_INTC_VEC) begin
            compare_word("irq_vec_o", exp, {30'b0, irq_vec_o});
            compare_word("irq_o", {31'b0, exp != 32'd3}, {31'b0, irq_o});
        end
    endtask

    // ----------------------------------------
    // Bus and pin tasks
    // ----------------------------------------
    // One single NONSEQ transfer; outputs sampled on the falling edge
    task automatic ahb_transfer(input logic [31:0] addr, input logic wr,
                                input logic [31:0] wdata, input logic exp_err,
                                output logic [31:0] data);
        int   cycles;
        logic first_resp;
        @(posedge clk);
        haddr_i  <= addr;
        htrans_i <= soc_pkg::NONSEQ;
        hwrite_i <= wr;
        // Address phase taken here, data phase follows
        @(posedge clk);
        htrans_i <= soc_pkg::IDLE;
        hwdata_i <= wdata;
        cycles     = 0;
        first_resp = 1'b0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles == 1) begin
                first_resp = hresp_o;
            end
        end while (!hready_o && cycles < HREADY_LIMIT);
        require(hready_o, $sformatf("hready_o stayed low for %0d cycles at %h", cycles, addr));
        compare_word("data phase cycles", exp_err ? 32'd2 : 32'd3, cycles);
        compare_word("hresp_o", {31'b0, exp_err}, {31'b0, hresp_o});
        // ERROR needs hresp high in both cycles
        if (exp_err) begin
            compare_word("hresp_o first cycle", 32'd1, {31'b0, first_resp});
        end
        data = hrdata_o;
    endtask

    task automatic poll_register(input logic [31:0] addr, input logic [31:0] mask,
                                 input logic [31:0] exp);
        logic [31:0] data;
        int          polls;
        polls = 0;
        do begin
            ahb_transfer(addr, 1'b0, 32'h0, 1'b0, data);
            polls++;
        end while (((data & mask) != exp) && (polls < POLL_LIMIT));
        require((data & mask) == exp,
                $sformatf("register %h never matched %h within %0d polls", addr, exp, polls));
    endtask

    task automatic drive_pins(input logic [31:0] value);
        @(posedge clk);
        gpio_i <= value;
        // Two synchronizer flops, then the edge flag
        repeat (3) @(posedge clk);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        errors   = 0;
        checks   = 0;
        seed     = 32'h2668_af1a;
        rst_i    = 1'b1;
        haddr_i  = '0;
        htrans_i = soc_pkg::IDLE;
        hwrite_i = 1'b0;
        hwdata_i = '0;
        gpio_i   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        compare_word("hready_o", 32'd1, {31'b0, hready_o});
        compare_word("hresp_o", 32'd0, {31'b0, hresp_o});
        compare_word("gpio_o", 32'd0, gpio_o);
        compare_word("gpio_oe_o", 32'd0, gpio_oe_o);
        compare_word("irq_o", 32'd0, {31'b0, irq_o});
        // Random pin pattern for the GPIO_IN readback
        rand_pins = $random(seed);
        vec_tab[RAND_SET].data = rand_pins;
        vec_tab[RAND_CHK].exp  = rand_pins;
        for (int i = 0; i < NUM_VEC; i++) begin
            case (vec_tab[i].op)
                OP_WRITE: begin
                    ahb_transfer(vec_tab[i].addr, 1'b1, vec_tab[i].data, vec_tab[i].err, rdata);
                end
                OP_READ: begin
                    ahb_transfer(vec_tab[i].addr, 1'b0, 32'h0, vec_tab[i].err, rdata);
                    if (!vec_tab[i].err) begin
                        compare_word("hrdata_o", vec_tab[i].exp, rdata);
                        ports_match_reg(vec_tab[i].addr, vec_tab[i].exp);
                    end
                end
                OP_WAIT: poll_register(vec_tab[i].addr, vec_tab[i].data, vec_tab[i].exp);
                default: drive_pins(vec_tab[i].data);
            endcase
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Bound from table length and worst entry
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the vector table finished, errors: %0d", errors);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* hw/periph_soc.sv */
// Peripheral subsystem top: AHB-Lite port, APB bridge, CMT, INTC and GPIO
`timescale 1ns/1ps

module periph_soc #(
    parameter int GPIO_W = 32,
    parameter int CMT_W  = 16
) (
    input  logic                        clk,
    input  logic                        rst_i,
    // AHB-Lite port
    input  logic [soc_pkg::ADDR_W-1:0]  haddr_i,
    input  soc_pkg::htrans_e            htrans_i,
    input  logic                        hwrite_i,
    input  logic [soc_pkg::DATA_W-1:0]  hwdata_i,
    output logic [soc_pkg::DATA_W-1:0]  hrdata_o,
    output logic                        hready_o,
    output logic                        hresp_o,
    // Pins and interrupt
    input  logic [GPIO_W-1:0]           gpio_i,
    output logic [GPIO_W-1:0]           gpio_o,
    output logic [GPIO_W-1:0]           gpio_oe_o,
    output logic                        irq_o,
    output logic [1:0]                  irq_vec_o
);

    // ----------------------------------------
    // APB and interrupt wiring
    // ----------------------------------------
    logic                         psel_cmt, psel_intc, psel_gpio;
    logic                         penable, pwrite;
    logic [soc_pkg::PADDR_W-1:0]  paddr;
    logic [soc_pkg::DATA_W-1:0]   pwdata;
    logic [soc_pkg::DATA_W-1:0]   prdata_cmt, prdata_intc, prdata_gpio;
    logic                         cmt0_irq, cmt1_irq, gpio_irq;
    logic [soc_pkg::IRQ_NUM-1:0]  irq_src;

    assign irq_src[soc_pkg::IRQ_CMT0] = cmt0_irq;
    assign irq_src[soc_pkg::IRQ_CMT1] = cmt1_irq;
    assign irq_src[soc_pkg::IRQ_GPIO] = gpio_irq;

    ahb_apb_bridge u_bridge (
        .clk(clk), .rst_i(rst_i),
        .haddr_i(haddr_i), .htrans_i(htrans_i), .hwrite_i(hwrite_i), .hwdata_i(hwdata_i),
        .hrdata_o(hrdata_o), .hready_o(hready_o), .hresp_o(hresp_o),
        .psel_cmt_o(psel_cmt), .psel_intc_o(psel_intc), .psel_gpio_o(psel_gpio),
        .penable_o(penable), .pwrite_o(pwrite), .paddr_o(paddr), .pwdata_o(pwdata),
        .prdata_cmt_i(prdata_cmt), .prdata_intc_i(prdata_intc), .prdata_gpio_i(prdata_gpio)
    );

    cmt_timer #(.CMT_W(CMT_W)) u_cmt (
        .clk(clk), .rst_i(rst_i),
        .psel_i(psel_cmt), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata_cmt),
        .cmt0_irq_o(cmt0_irq), .cmt1_irq_o(cmt1_irq)
    );

    intc_ctrl u_intc (
        .clk(clk), .rst_i(rst_i),
        .psel_i(psel_intc), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata_intc),
        .irq_src_i(irq_src), .irq_o(irq_o), .irq_vec_o(irq_vec_o)
    );

    gpio_port #(.GPIO_W(GPIO_W)) u_gpio (
        .clk(clk), .rst_i(rst_i),
        .psel_i(psel_gpio), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata_gpio),
        .gpio_i(gpio_i), .gpio_o(gpio_o), .gpio_oe_o(gpio_oe_o), .gpio_irq_o(gpio_irq)
    );

endmodule

/* hw/gpio_port.sv */
// GPIO on APB with output, direction, synchronized input and rising-edge interrupts
`timescale 1ns/1ps

module gpio_port #(
    parameter int GPIO_W = 32
) (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         psel_i,
    input  logic                         penable_i,
    input  logic                         pwrite_i,
    input  logic [soc_pkg::PADDR_W-1:0]  paddr_i,
    input  logic [soc_pkg::DATA_W-1:0]   pwdata_i,
    output logic [soc_pkg::DATA_W-1:0]   prdata_o,
    input  logic [GPIO_W-1:0]            gpio_i,
    output logic [GPIO_W-1:0]            gpio_o,
    output logic [GPIO_W-1:0]            gpio_oe_o,
    output logic                         gpio_irq_o
);

    logic [GPIO_W-1:0] out_q;
    logic [GPIO_W-1:0] oe_q;
    logic [GPIO_W-1:0] ie_q;
    logic [GPIO_W-1:0] edge_q;
    logic [GPIO_W-1:0] sync1_q;
    logic [GPIO_W-1:0] sync2_q;
    logic [GPIO_W-1:0] prev_q;
    logic              wr_en;

    assign wr_en = psel_i && penable_i && pwrite_i;

    // ----------------------------------------
    // Registers and input path
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_q   <= '0;
            oe_q    <= '0;
            ie_q    <= '0;
            edge_q  <= '0;
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
        end else begin
            // Two-flop synchronizer, then edge history
            sync1_q <= gpio_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
            if (wr_en && paddr_i == soc_pkg::GPIO_OUT) out_q <= pwdata_i[GPIO_W-1:0];
            if (wr_en && paddr_i == soc_pkg::GPIO_OE)  oe_q  <= pwdata_i[GPIO_W-1:0];
            if (wr_en && paddr_i == soc_pkg::GPIO_IE)  ie_q  <= pwdata_i[GPIO_W-1:0];
            // Sticky rise flags, write-1 clears
            edge_q <= (edge_q & ~((wr_en && paddr_i == soc_pkg::GPIO_EDGE) ?
                       pwdata_i[GPIO_W-1:0] : '0)) | (sync2_q & ~prev_q);
        end
    end

    // Read mux
    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            soc_pkg::GPIO_OUT:  prdata_o[GPIO_W-1:0] = out_q;
            soc_pkg::GPIO_OE:   prdata_o[GPIO_W-1:0] = oe_q;
            soc_pkg::GPIO_IN:   prdata_o[GPIO_W-1:0] = sync2_q;
            soc_pkg::GPIO_IE:   prdata_o[GPIO_W-1:0] = ie_q;
            soc_pkg::GPIO_EDGE: prdata_o[GPIO_W-1:0] = edge_q;
            default:            prdata_o             = '0;
        endcase
    end

    assign gpio_o     = out_q;
    assign gpio_oe_o  = oe_q;
    assign gpio_irq_o = |(edge_q & ie_q);

endmodule

/* hw/intc_ctrl.sv */
// Interrupt controller on APB: pending capture, enable mask and priority vector
`timescale 1ns/1ps

module intc_ctrl (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         psel_i,
    input  logic                         penable_i,
    input  logic                         pwrite_i,
    input  logic [soc_pkg::PADDR_W-1:0]  paddr_i,
    input  logic [soc_pkg::DATA_W-1:0]   pwdata_i,
    output logic [soc_pkg::DATA_W-1:0]   prdata_o,
    input  logic [soc_pkg::IRQ_NUM-1:0]  irq_src_i,
    output logic                         irq_o,
    output logic [1:0]                   irq_vec_o
);

    logic [soc_pkg::IRQ_NUM-1:0] pend_q;
    logic [soc_pkg::IRQ_NUM-1:0] enable_q;
    logic [soc_pkg::IRQ_NUM-1:0] active;
    logic [1:0]                  vec;

    // ----------------------------------------
    // Pending and enable registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pend_q   <= '0;
            enable_q <= '0;
        end else begin
            // Level copy, cleared at the source
            pend_q <= irq_src_i;
            if (psel_i && penable_i && pwrite_i && paddr_i == soc_pkg::INTC_ENABLE) begin
                enable_q <= pwdata_i[soc_pkg::IRQ_NUM-1:0];
            end
        end
    end

    assign active = pend_q & enable_q;

    // Lowest index wins, 3 means none
    always_comb begin
        vec = 2'd3;
        for (int i = soc_pkg::IRQ_NUM - 1; i >= 0; i--) begin
            if (active[i]) begin
                vec = 2'(i);
            end
        end
    end

    assign irq_o     = |active;
    assign irq_vec_o = vec;

    // Read mux
    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            soc_pkg::INTC_PEND:   prdata_o[soc_pkg::IRQ_NUM-1:0] = pend_q;
            soc_pkg::INTC_ENABLE: prdata_o[soc_pkg::IRQ_NUM-1:0] = enable_q;
            soc_pkg::INTC_VEC:    prdata_o[1:0]                  = vec;
            default:              prdata_o                       = '0;
        endcase
    end

    // A request always carries a real vector
    a_vec_valid: assert property (@(posedge clk) disable iff (rst_i)
        irq_o |-> irq_vec_o != 2'd3);

endmodule

/* hw/cmt_timer.sv */
// Two-channel compare-match timer on APB, one interrupt flag per channel
`timescale 1ns/1ps

module cmt_timer #(
    parameter int CMT_W = 16
) (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         psel_i,
    input  logic                         penable_i,
    input  logic                         pwrite_i,
    input  logic [soc_pkg::PADDR_W-1:0]  paddr_i,
    input  logic [soc_pkg::DATA_W-1:0]   pwdata_i,
    output logic [soc_pkg::DATA_W-1:0]   prdata_o,
    output logic                         cmt0_irq_o,
    output logic                         cmt1_irq_o
);

    logic [1:0]       ctrl_q;
    logic [1:0]       stat_q;
    logic [CMT_W-1:0] cmp_q [2];
    logic [CMT_W-1:0] cnt_q [2];
    logic             wr_en;
    logic [1:0]       cmp_wr;

    // Write commits at the end of the access cycle
    assign wr_en     = psel_i && penable_i && pwrite_i;
    assign cmp_wr[0] = wr_en && (paddr_i == soc_pkg::CMT_CMP0);
    assign cmp_wr[1] = wr_en && (paddr_i == soc_pkg::CMT_CMP1);

    // ----------------------------------------
    // Control and compare registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ctrl_q <= '0;
        end else if (wr_en && paddr_i == soc_pkg::CMT_CTRL) begin
            ctrl_q <= pwdata_i[1:0];
        end
    end

    // Per-channel counter, compare and flag
    always_ff @(posedge clk) begin
        if (rst_i) begin
            stat_q <= '0;
            for (int i = 0; i < 2; i++) begin
                cnt_q[i] <= '0;
                cmp_q[i] <= '1;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                // New compare restarts the count
                if (cmp_wr[i]) begin
                    cmp_q[i] <= pwdata_i[CMT_W-1:0];
                    cnt_q[i] <= '0;
                end else if (ctrl_q[i]) begin
                    cnt_q[i] <= (cnt_q[i] == cmp_q[i]) ? '0 : cnt_q[i] + 1'b1;
                end
                // Match sets, write-1 clears, set wins
                stat_q[i] <= (stat_q[i] && !(wr_en && paddr_i == soc_pkg::CMT_STAT
                              && pwdata_i[i]))
                             || (ctrl_q[i] && !cmp_wr[i] && cnt_q[i] == cmp_q[i]);
            end
        end
    end

    // ----------------------------------------
    // Read mux
    // ----------------------------------------
    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            soc_pkg::CMT_CTRL: prdata_o[1:0]       = ctrl_q;
            soc_pkg::CMT_STAT: prdata_o[1:0]       = stat_q;
            soc_pkg::CMT_CMP0: prdata_o[CMT_W-1:0] = cmp_q[0];
            soc_pkg::CMT_CMP1: prdata_o[CMT_W-1:0] = cmp_q[1];
            soc_pkg::CMT_CNT0: prdata_o[CMT_W-1:0] = cnt_q[0];
            soc_pkg::CMT_CNT1: prdata_o[CMT_W-1:0] = cnt_q[1];
            default:           prdata_o            = '0;
        endcase
    end

    assign cmt0_irq_o = stat_q[0];
    assign cmt1_irq_o = stat_q[1];

    // Count stays inside 0..CMP across compare rewrites
    a_cnt0_range: assert property (@(posedge clk) disable iff (rst_i)
        ctrl_q[0] |-> cnt_q[0] <= cmp_q[0]);
    a_cnt1_range: assert property (@(posedge clk) disable iff (rst_i)
        ctrl_q[1] |-> cnt_q[1] <= cmp_q[1]);

endmodule

/* hw/ahb_apb_bridge.sv */
// AHB-Lite subordinate that decodes the peripheral windows and runs one APB requester
`timescale 1ns/1ps

module ahb_apb_bridge (
    input  logic                         clk,
    input  logic                         rst_i,
    // AHB-Lite side
    input  logic [soc_pkg::ADDR_W-1:0]   haddr_i,
    input  soc_pkg::htrans_e             htrans_i,
    input  logic                         hwrite_i,
    input  logic [soc_pkg::DATA_W-1:0]   hwdata_i,
    output logic [soc_pkg::DATA_W-1:0]   hrdata_o,
    output logic                         hready_o,
    output logic                         hresp_o,
    // APB side
    output logic                         psel_cmt_o,
    output logic                         psel_intc_o,
    output logic                         psel_gpio_o,
    output logic                         penable_o,
    output logic                         pwrite_o,
    output logic [soc_pkg::PADDR_W-1:0]  paddr_o,
    output logic [soc_pkg::DATA_W-1:0]   pwdata_o,
    input  logic [soc_pkg::DATA_W-1:0]   prdata_cmt_i,
    input  logic [soc_pkg::DATA_W-1:0]   prdata_intc_i,
    input  logic [soc_pkg::DATA_W-1:0]   prdata_gpio_i
);

    soc_pkg::bridge_state_e             state_q;
    soc_pkg::apb_slave_e                sel_q;
    soc_pkg::apb_slave_e                dec_slv;
    logic                               write_q;
    logic [soc_pkg::PADDR_W-1:0]        paddr_q;
    logic [soc_pkg::DATA_W-1:0]         hrdata_q;
    logic [soc_pkg::DATA_W-1:0]         prdata_mux;
    logic                               hready_q;
    logic                               hresp_q;
    logic                               accept;
    logic                               apb_active;

    // ----------------------------------------
    // Address decode
    // ----------------------------------------
    always_comb begin
        case (haddr_i & soc_pkg::PERIPH_MASK)
            soc_pkg::CMT_BASE:  dec_slv = soc_pkg::SLV_CMT;
            soc_pkg::INTC_BASE: dec_slv = soc_pkg::SLV_INTC;
            soc_pkg::GPIO_BASE: dec_slv = soc_pkg::SLV_GPIO;
            default:            dec_slv = soc_pkg::SLV_NONE;
        endcase
    end

    // Only single NONSEQ transfers, taken while idle
    assign accept = (htrans_i == soc_pkg::NONSEQ) && hready_q && (state_q == soc_pkg::ST_IDLE);

    // Read data back from the addressed slave
    always_comb begin
        case (sel_q)
            soc_pkg::SLV_CMT:  prdata_mux = prdata_cmt_i;
            soc_pkg::SLV_INTC: prdata_mux = prdata_intc_i;
            soc_pkg::SLV_GPIO: prdata_mux = prdata_gpio_i;
            default:           prdata_mux = '0;
        endcase
    end

    // ----------------------------------------
    // Bridge FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q  <= soc_pkg::ST_IDLE;
            sel_q    <= soc_pkg::SLV_NONE;
            write_q  <= 1'b0;
            hready_q <= 1'b1;
            hresp_q  <= 1'b0;
        end else begin
            case (state_q)
                soc_pkg::ST_IDLE: begin
                    // ERROR tail ends here
                    hresp_q <= 1'b0;
                    if (accept) begin
                        sel_q    <= dec_slv;
                        write_q  <= hwrite_i;
                        hready_q <= 1'b0;
                        if (dec_slv == soc_pkg::SLV_NONE) begin
                            state_q <= soc_pkg::ST_ERROR;
                            hresp_q <= 1'b1;
                        end else begin
                            state_q <= soc_pkg::ST_SETUP;
                        end
                    end
                end
                soc_pkg::ST_SETUP: state_q <= soc_pkg::ST_ACCESS;
                soc_pkg::ST_ACCESS: begin
                    state_q  <= soc_pkg::ST_IDLE;
                    hready_q <= 1'b1;
                end
                // Second ERROR cycle, hresp stays high
                default: begin
                    state_q  <= soc_pkg::ST_IDLE;
                    hready_q <= 1'b1;
                end
            endcase
        end
    end

    // Offset and read data
    always_ff @(posedge clk) begin
        if (accept) begin
            paddr_q <= haddr_i[soc_pkg::PADDR_W-1:0];
        end
        if (state_q == soc_pkg::ST_ACCESS && !write_q) begin
            hrdata_q <= prdata_mux;
        end
    end

    assign apb_active  = (state_q == soc_pkg::ST_SETUP) || (state_q == soc_pkg::ST_ACCESS);
    assign psel_cmt_o  = apb_active && (sel_q == soc_pkg::SLV_CMT);
    assign psel_intc_o = apb_active && (sel_q == soc_pkg::SLV_INTC);
    assign psel_gpio_o = apb_active && (sel_q == soc_pkg::SLV_GPIO);
    assign penable_o   = (state_q == soc_pkg::ST_ACCESS);
    assign pwrite_o    = write_q;
    assign paddr_o     = paddr_q;
    // Master holds HWDATA for the whole data phase
    assign pwdata_o    = hwdata_i;
    assign hrdata_o    = hrdata_q;
    assign hready_o    = hready_q;
    assign hresp_o     = hresp_q;

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_psel_onehot: assert property (@(posedge clk) disable iff (rst_i)
        $onehot0({psel_cmt_o, psel_intc_o, psel_gpio_o}));
    a_penable_sel: assert property (@(posedge clk) disable iff (rst_i)
        penable_o |-> (psel_cmt_o || psel_intc_o || psel_gpio_o));
    a_idle_ready: assert property (@(posedge clk) disable iff (rst_i)
        (state_q == soc_pkg::ST_IDLE) |-> hready_o);

endmodule

/* hw/soc_pkg.sv */
// Shared widths, address map, enums and register offsets for the peripheral SoC
package soc_pkg;

    // ----------------------------------------
    // Bus widths
    // ----------------------------------------
    parameter int ADDR_W  = 32;
    parameter int DATA_W  = 32;
    // Offset inside a peripheral window
    parameter int PADDR_W = 8;

    // ----------------------------------------
    // Address map
    // ----------------------------------------
    parameter logic [ADDR_W-1:0] CMT_BASE    = 32'habcc0000;
    parameter logic [ADDR_W-1:0] INTC_BASE   = 32'habcc1000;
    parameter logic [ADDR_W-1:0] GPIO_BASE   = 32'habcc2000;
    // 4 KB windows
    parameter logic [ADDR_W-1:0] PERIPH_MASK = 32'hfffff000;

    // Interrupt sources, index 0 wins
    parameter int IRQ_NUM  = 3;
    parameter int IRQ_CMT0 = 0;
    parameter int IRQ_CMT1 = 1;
    parameter int IRQ_GPIO = 2;

    // AHB transfer type
    typedef enum logic [1:0] {IDLE, BUSY, NONSEQ, SEQ} htrans_e;

    // APB slave select
    typedef enum logic [1:0] {SLV_CMT, SLV_INTC, SLV_GPIO, SLV_NONE} apb_slave_e;

    // Bridge FSM
    typedef enum logic [1:0] {ST_IDLE, ST_SETUP, ST_ACCESS, ST_ERROR} bridge_state_e;

    // ----------------------------------------
    // Register offsets
    // ----------------------------------------
    typedef enum logic [7:0] {
        CMT_CTRL = 8'h00,
        CMT_STAT = 8'h04,
        CMT_CMP0 = 8'h08,
        CMT_CMP1 = 8'h0C,
        CMT_CNT0 = 8'h10,
        CMT_CNT1 = 8'h14
    } cmt_reg_e;

    typedef enum logic [7:0] {
        INTC_PEND   = 8'h00,
        INTC_ENABLE = 8'h04,
        INTC_VEC    = 8'h08
    } intc_reg_e;

    typedef enum logic [7:0] {
        GPIO_OUT  = 8'h00,
        GPIO_OE   = 8'h04,
        GPIO_IN   = 8'h08,
        GPIO_IE   = 8'h0C,
        GPIO_EDGE = 8'h10
    } gpio_reg_e;

endpackage
